// File: Makefile
TOP  := tb_wb_subsystem
SRCS := $(filter-out +%,$(shell cat project.f))

all: run

obj_dir/V$(TOP): project.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f project.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: project.f
verilog/wb_pkg.sv
verilog/wb_arbiter.sv
verilog/wishbone_decoder.sv
verilog/wb_sram.sv
verilog/wb_gpio.sv
verilog/team_regs.sv
verilog/wb_subsystem.sv
testbench/tb_wb_subsystem.sv

// File: testbench/tb_wb_subsystem.sv
`timescale 1ns/1ns

module tb_wb_subsystem import wb_pkg::*; ();

    // one table row
    typedef struct packed {
        int          master;
        bit          we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        bit          chk;
    } step_t;

    logic                              CLK;
    logic                              nRST;
    logic [NUM_MASTERS-1:0]            m_cyc;
    logic [NUM_MASTERS-1:0]            m_stb;
    logic [NUM_MASTERS-1:0]            m_we;
    logic [NUM_MASTERS-1:0][ADR_W-1:0] m_adr;
    logic [NUM_MASTERS-1:0][DAT_W-1:0] m_dat_w;
    logic [NUM_MASTERS-1:0][SEL_W-1:0] m_sel;
    logic [NUM_MASTERS-1:0]            m_ack;
    logic [DAT_W-1:0]                  m_dat_r;
    logic [GPIO_WIDTH-1:0]             gpio_in;
    logic [GPIO_WIDTH-1:0]             gpio_out;

    step_t       steps[$];
    int          ack_order[$];
    // reference model state
    logic [31:0] sram_m [SRAM_WORDS];
    logic [31:0] team_m [NUM_TEAMS][4];
    logic [15:0] gpio_m;
    logic [15:0] pad_val;
    int          n_checks;
    int          n_errors;

    wb_subsystem i_dut (
        .CLK(CLK), .nRST(nRST),
        .m_cyc(m_cyc), .m_stb(m_stb), .m_we(m_we), .m_adr(m_adr),
        .m_dat_w(m_dat_w), .m_sel(m_sel), .m_ack(m_ack), .m_dat_r(m_dat_r),
        .gpio_in(gpio_in), .gpio_out(gpio_out)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    ////////////////////
    // reference model
    ////////////////////

    // -1 unmapped, 0 sram, 1 gpio, 2+n team n
    function automatic int slot_of(logic [31:0] adr);
        if (adr[31:16] == 16'h3300) return 0;
        if (adr[31:16] == 16'h3200) return 1;
        if (adr[31:24] == 8'h30 && int'(adr[19:16]) < NUM_TEAMS) return 2 + int'(adr[19:16]);
        return -1;
    endfunction

    // byte lanes of dat replace those of old where sel is set
    function automatic logic [31:0] merge(logic [31:0] old, logic [31:0] dat, logic [3:0] sel);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) r[8*b +: 8] = dat[8*b +: 8];
        end
        return r;
    endfunction

    function automatic void model_write(logic [31:0] adr, logic [31:0] dat, logic [3:0] sel);
        int          s;
        logic [31:0] g;
        s = slot_of(adr);
        if (s == 0) begin
            sram_m[adr[9:2]] = merge(sram_m[adr[9:2]], dat, sel);
        end else if (s == 1 && adr[15:0] == 16'h0000) begin
            // only the low two lanes exist on the pads
            g      = merge({16'h0, gpio_m}, dat, sel);
            gpio_m = g[15:0];
        end else if (s >= 2) begin
            team_m[s-2][adr[3:2]] = merge(team_m[s-2][adr[3:2]], dat, sel);
        end
    endfunction

    function automatic logic [31:0] model_read(logic [31:0] adr);
        int s;
        s = slot_of(adr);
        if (s < 0) return 32'hDEAD_BEEF;
        if (s == 0) return sram_m[adr[9:2]];
        if (s >= 2) return team_m[s-2][adr[3:2]];
        // gpio offsets
        if (adr[15:0] == 16'h0000) return {16'h0, gpio_m};
        if (adr[15:0] == 16'h0004) return {16'h0, pad_val};
        return 32'h0;
    endfunction

    task automatic check(string name, logic [31:0] exp, logic [31:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    ////////////////////
    // bus access
    ////////////////////

    // one classic cycle on master m that ends on the edge after ack
    task automatic bus_xfer(int m, bit we, logic [31:0] adr, logic [31:0] dat,
                            logic [3:0] sel, output logic [31:0] rdata);
        int wait_cnt;
        bit seen;
        wait_cnt = 0;
        seen     = 1'b0;
        rdata    = 'x;
        @(posedge CLK);
        m_cyc[m]   <= 1'b1;
        m_stb[m]   <= 1'b1;
        m_we[m]    <= we;
        m_adr[m]   <= adr;
        m_dat_w[m] <= dat;
        m_sel[m]   <= sel;
        // sample away from the edge
        while (!seen && wait_cnt < 50) begin
            @(negedge CLK);
            if (m_ack[m]) begin
                seen  = 1'b1;
                rdata = m_dat_r;
                ack_order.push_back(m);
            end else begin
                wait_cnt++;
            end
        end
        @(posedge CLK);
        m_cyc[m] <= 1'b0;
        m_stb[m] <= 1'b0;
        if (!seen) begin
            n_errors++;
            $display("timeout: master %0d saw no ack for address %h within 50 cycles", m, adr);
        end
    endtask

    function automatic void add_step(int m, bit we, logic [31:0] adr, logic [31:0] dat,
                                     logic [3:0] sel, bit chk);
        step_t s;
        s.master = m;
        s.we     = we;
        s.adr    = adr;
        s.dat    = dat;
        s.sel    = sel;
        s.chk    = chk;
        steps.push_back(s);
    endfunction

    task automatic run_steps();
        logic [31:0] rd;
        step_t       s;
        foreach (steps[i]) begin
            s = steps[i];
            bus_xfer(s.master, s.we, s.adr, s.dat, s.sel, rd);
            if (s.we) begin
                model_write(s.adr, s.dat, s.sel);
                // pads follow the output register
                if (slot_of(s.adr) == 1) check("gpio_out", {16'h0, gpio_m}, {16'h0, gpio_out});
            end else if (s.chk) begin
                check($sformatf("m_dat_r[%h]", s.adr), model_read(s.adr), rd);
            end
        end
        steps.delete();
    endtask

    function automatic void load_table();
        // sram gets full words first so no lane stays unknown
        add_step(0, 1'b1, 32'h3300_0000, $urandom, 4'hF, 1'b0);
        add_step(0, 1'b0, 32'h3300_0000, 32'h0, 4'hF, 1'b1);
        add_step(0, 1'b1, 32'h3300_0010, $urandom, 4'hF, 1'b0);
        add_step(0, 1'b1, 32'h3300_0010, $urandom, 4'b0101, 1'b0);
        add_step(0, 1'b0, 32'h3300_0010, 32'h0, 4'hF, 1'b1);
        add_step(1, 1'b1, 32'h3300_03FC, $urandom, 4'hF, 1'b0);
        add_step(1, 1'b1, 32'h3300_03FC, $urandom, 4'b1000, 1'b0);
        add_step(0, 1'b1, 32'h3300_03FC, $urandom, 4'b0010, 1'b0);
        add_step(1, 0, 32'h3300_03FC, 32'h0, 4'hF, 1'b1);
        // gpio out register, input port, dead offset
        add_step(0, 1'b1, 32'h3200_0000, $urandom, 4'hF, 1'b0);
        add_step(0, 1'b0, 32'h3200_0000, 32'h0, 4'hF, 1'b1);
        add_step(1, 1'b1, 32'h3200_0000, $urandom, 4'b0010, 1'b0);
        add_step(1, 1'b0, 32'h3200_0000, 32'h0, 4'hF, 1'b1);
        add_step(0, 1'b0, 32'h3200_0004, 32'h0, 4'hF, 1'b1);
        add_step(0, 1'b1, 32'h3200_0004, $urandom, 4'hF, 1'b0);
        add_step(0, 1'b0, 32'h3200_0004, 32'h0, 4'hF, 1'b1);
        add_step(0, 1'b0, 32'h3200_0008, 32'h0, 4'hF, 1'b1);
        // same offset in every team window
        for (int t = 0; t < NUM_TEAMS; t++) begin
            add_step(t % 2, 1'b1, 32'h3000_0004 | (32'(t) << 16), $urandom, 4'hF, 1'b0);
        end
        for (int t = 0; t < NUM_TEAMS; t++) begin
            add_step(0, 1'b0, 32'h3000_0004 | (32'(t) << 16), 32'h0, 4'hF, 1'b1);
        end
        add_step(1, 1'b1, 32'h3002_000C, $urandom, 4'b0110, 1'b0);
        add_step(1, 1'b0, 32'h3002_000C, 32'h0, 4'hF, 1'b1);
        // holes in the map
        add_step(0, 1'b0, 32'h3006_0000, 32'h0, 4'hF, 1'b1);
        add_step(1, 1'b0, 32'h300F_0004, 32'h0, 4'hF, 1'b1);
        add_step(0, 1'b1, 32'h3100_0000, $urandom, 4'hF, 1'b0);
        add_step(0, 1'b0, 32'h3100_0000, 32'h0, 4'hF, 1'b1);
        add_step(1, 1'b0, 32'h0000_0010, 32'h0, 4'hF, 1'b1);
    endfunction

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        logic [31:0] rd0;
        logic [31:0] rd1;
        logic [31:0] wr;
        logic [31:0] team_adr;
        void'($urandom(53607));
        n_checks = 0;
        n_errors = 0;
        gpio_m   = 16'h0;
        team_m   = '{default: '{default: 32'h0}};
        pad_val  = 16'($urandom);
        nRST    <= 1'b0;
        m_cyc   <= '0;
        m_stb   <= '0;
        m_we    <= '0;
        m_adr   <= '0;
        m_dat_w <= '0;
        m_sel   <= '0;
        gpio_in <= '0;
        repeat (8) @(posedge CLK);
        nRST    <= 1'b1;
        gpio_in <= pad_val;
        @(negedge CLK);
        check("m_ack", 32'h0, {30'h0, m_ack});
        check("gpio_out", 32'h0, {16'h0, gpio_out});

        load_table();
        run_steps();

        // both masters start together every round
        ack_order.delete();
        for (int r = 0; r < 6; r++) begin
            wr       = $urandom;
            team_adr = 32'h3000_0004 | (32'(r) << 16);
            // a lone access decides who was served last
            bus_xfer(r % 2, 1'b0, 32'h3200_0004, 32'h0, 4'hF, rd0);
            check($sformatf("m_dat_r[%h]", 32'h3200_0004), model_read(32'h3200_0004), rd0);
            fork
                bus_xfer(0, 1'b1, 32'h3300_0100 + 32'(4 * r), wr, 4'hF, rd0);
                bus_xfer(1, 1'b0, team_adr, 32'h0, 4'hF, rd1);
            join
            model_write(32'h3300_0100 + 32'(4 * r), wr, 4'hF);
            check($sformatf("m_dat_r[%h]", team_adr), model_read(team_adr), rd1);
        end
        check("ack count", 32'd18, 32'(ack_order.size()));
        // grants must swap owner every time
        for (int i = 1; i < ack_order.size(); i++) begin
            check("m_ack owner", 32'(1 - ack_order[i-1]), 32'(ack_order[i]));
        end
        for (int r = 0; r < 6; r++) begin
            add_step(r % 2, 1'b0, 32'h3300_0100 + 32'(4 * r), 32'h0, 4'hF, 1'b1);
        end
        run_steps();

        $display("checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: verilog/team_regs.sv
`timescale 1ns/1ns

module team_regs import wb_pkg::*; (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  logic [ADR_W-1:0] adr,
    input  logic [DAT_W-1:0] dat_w,
    input  logic [SEL_W-1:0] sel,
    output logic             ack,
    output logic [DAT_W-1:0] dat_r
);

    logic [3:0][DAT_W-1:0]  regs;
    logic [TEAM_CNT_W-1:0]  cnt;
    wb_addr_u               a;
    logic                   done;

    assign a = adr;
    // wait states used up, answer on this edge
    assign done = cyc && stb && !ack && (cnt == TEAM_CNT_W'(TEAM_ACK_DELAY - 1));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ack  <= 1'b0;
            cnt  <= '0;
            regs <= '0;
        end else if (done) begin
            ack <= 1'b1;
            cnt <= '0;
            if (we) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (sel[b]) begin
                        regs[a.fixed.offset[3:2]][8*b +: 8] <= dat_w[8*b +: 8];
                    end
                end
            end
        end else if (cyc && stb && !ack) begin
            // still counting wait states
            cnt <= cnt + 1'b1;
        end else begin
            ack <= 1'b0;
            cnt <= '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (done) begin
            dat_r <= regs[a.fixed.offset[3:2]];
        end
    end

endmodule

// File: verilog/wb_arbiter.sv
`timescale 1ns/1ns

module wb_arbiter import wb_pkg::*; (
    input  logic                                CLK,
    input  logic                                nRST,

    // master side
    input  logic [NUM_MASTERS-1:0]              m_cyc,
    input  logic [NUM_MASTERS-1:0]              m_stb,
    input  logic [NUM_MASTERS-1:0]              m_we,
    input  logic [NUM_MASTERS-1:0][ADR_W-1:0]   m_adr,
    input  logic [NUM_MASTERS-1:0][DAT_W-1:0]   m_dat_w,
    input  logic [NUM_MASTERS-1:0][SEL_W-1:0]   m_sel,
    output logic [NUM_MASTERS-1:0]              m_ack,

    // shared bus toward the decoder
    output logic                                cyc,
    output logic                                stb,
    output logic                                we,
    output logic [ADR_W-1:0]                    adr,
    output logic [DAT_W-1:0]                    dat_w,
    output logic [SEL_W-1:0]                    sel,
    input  logic                                ack
);

    logic              gnt_valid;
    logic [MIDX_W-1:0] gnt_idx;
    logic [MIDX_W-1:0] last;
    logic [MIDX_W-1:0] other;
    logic [MIDX_W-1:0] pick;

    // the master not served last gets first look
    assign other = last + 1'b1;
    assign pick  = m_cyc[other] ? other : last;

    ////////////////////
    // grant register
    ////////////////////
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            gnt_valid <= 1'b0;
            gnt_idx   <= '0;
            last      <= '0;
        end else if (!gnt_valid) begin
            // idle, take any request on this edge
            if (|m_cyc) begin
                gnt_valid <= 1'b1;
                gnt_idx   <= pick;
                last      <= pick;
            end
        end else if (!m_cyc[gnt_idx]) begin
            // owner let go of cyc
            gnt_valid <= 1'b0;
        end
    end

    ////////////////////
    // bus mux, ack demux
    ////////////////////
    always_comb begin
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        sel   = '0;
        m_ack = '0;
        if (gnt_valid) begin
            cyc            = m_cyc[gnt_idx];
            stb            = m_stb[gnt_idx];
            we             = m_we[gnt_idx];
            adr            = m_adr[gnt_idx];
            dat_w          = m_dat_w[gnt_idx];
            sel            = m_sel[gnt_idx];
            // only the owner ever sees ack
            m_ack[gnt_idx] = ack;
        end
    end

endmodule

// File: verilog/wb_gpio.sv
`timescale 1ns/1ns

module wb_gpio import wb_pkg::*; (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  cyc,
    input  logic                  stb,
    input  logic                  we,
    input  logic [ADR_W-1:0]      adr,
    input  logic [DAT_W-1:0]      dat_w,
    input  logic [SEL_W-1:0]      sel,
    output logic                  ack,
    output logic [DAT_W-1:0]      dat_r,
    input  logic [GPIO_WIDTH-1:0] gpio_in,
    output logic [GPIO_WIDTH-1:0] gpio_out
);

    logic [GPIO_WIDTH-1:0] out_reg;
    logic [GPIO_WIDTH-1:0] in_meta;
    logic [GPIO_WIDTH-1:0] in_sync;
    wb_addr_u              a;
    logic                  req;

    assign a        = adr;
    assign req      = cyc && stb && !ack;
    assign gpio_out = out_reg;

    ////////////////////
    // control flops
    ////////////////////
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ack     <= 1'b0;
            out_reg <= '0;
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            ack     <= req;
            // pads are asynchronous, two stages
            in_meta <= gpio_in;
            in_sync <= in_meta;
            // only offset 0 is writable
            if (req && we && a.fixed.offset == GPIO_OUT_OFS) begin
                for (int b = 0; b < GPIO_WIDTH / 8; b++) begin
                    if (sel[b]) begin
                        out_reg[8*b +: 8] <= dat_w[8*b +: 8];
                    end
                end
            end
        end
    end

    // read mux, captured with the ack
    always_ff @(posedge CLK) begin
        if (req) begin
            case (a.fixed.offset)
                GPIO_OUT_OFS: dat_r <= DAT_W'(out_reg);
                GPIO_IN_OFS:  dat_r <= DAT_W'(in_sync);
                default:      dat_r <= '0;
            endcase
        end
    end

endmodule

// File: verilog/wb_pkg.sv
package wb_pkg;

    ////////////////////
    // bus shape
    ////////////////////
    localparam int ADR_W       = 32;
    localparam int DAT_W       = 32;
    localparam int SEL_W       = DAT_W / 8;
    localparam int NUM_MASTERS = 2;
    localparam int MIDX_W      = $clog2(NUM_MASTERS);

    // slave slots: sram, gpio, then one per team
    localparam int NUM_TEAMS  = 6;
    localparam int NUM_SLAVES = NUM_TEAMS + 2;
    localparam int SLOT_W     = $clog2(NUM_SLAVES);
    localparam int SLOT_SRAM  = 0;
    localparam int SLOT_GPIO  = 1;
    localparam int SLOT_TEAM0 = 2;

    // decoder one-hot state bits
    localparam int ST_W    = NUM_SLAVES + 2;
    localparam int ST_IDLE = 0;
    localparam int ST_RESP = NUM_SLAVES + 1;

    ////////////////////
    // address map
    ////////////////////
    localparam logic [7:0]  REGION_TEAM = 8'h30;
    localparam logic [7:0]  REGION_GPIO = 8'h32;
    localparam logic [7:0]  REGION_SRAM = 8'h33;
    localparam logic [15:0] PAGE_GPIO   = {REGION_GPIO, 8'h00};
    localparam logic [15:0] PAGE_SRAM   = {REGION_SRAM, 8'h00};

    // filler word for anything that hits no slave
    localparam logic [DAT_W-1:0] UNMAPPED_DATA = 32'hDEAD_BEEF;

    // slave sizes and offsets
    localparam int          SRAM_WORDS     = 256;
    localparam int          SRAM_AW        = $clog2(SRAM_WORDS);
    localparam int          GPIO_WIDTH     = 16;
    localparam logic [15:0] GPIO_OUT_OFS   = 16'h0000;
    localparam logic [15:0] GPIO_IN_OFS    = 16'h0004;
    localparam int          TEAM_ACK_DELAY = 2;
    localparam int          TEAM_CNT_W     = $clog2(TEAM_ACK_DELAY + 1);

    // one bus address, seen as fixed page or as team window
    typedef union packed {
        struct packed {
            logic [15:0] page;
            logic [15:0] offset;
        } fixed;
        struct packed {
            logic [7:0]  region;
            logic [3:0]  rsvd;
            logic [3:0]  team;
            logic [15:0] offset;
        } team;
    } wb_addr_u;

endpackage

// File: verilog/wb_sram.sv
`timescale 1ns/1ns

module wb_sram import wb_pkg::*; (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  logic [ADR_W-1:0] adr,
    input  logic [DAT_W-1:0] dat_w,
    input  logic [SEL_W-1:0] sel,
    output logic             ack,
    output logic [DAT_W-1:0] dat_r
);

    logic [DAT_W-1:0]   mem [SRAM_WORDS];
    wb_addr_u           a;
    logic [SRAM_AW-1:0] idx;
    logic               req;

    assign a   = adr;
    // word index from the byte offset
    assign idx = a.fixed.offset[SRAM_AW+1:2];
    // new access only while ack is low
    assign req = cyc && stb && !ack;

    // ack one cycle after stb, then low again
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ack <= 1'b0;
        end else begin
            ack <= req;
        end
    end

    // array and read port
    always_ff @(posedge CLK) begin
        if (req) begin
            dat_r <= mem[idx];
            if (we) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (sel[b]) begin
                        mem[idx][8*b +: 8] <= dat_w[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

// File: verilog/wb_subsystem.sv
`timescale 1ns/1ns

module wb_subsystem import wb_pkg::*; (
    input  logic                                CLK,
    input  logic                                nRST,

    // master ports
    input  logic [NUM_MASTERS-1:0]              m_cyc,
    input  logic [NUM_MASTERS-1:0]              m_stb,
    input  logic [NUM_MASTERS-1:0]              m_we,
    input  logic [NUM_MASTERS-1:0][ADR_W-1:0]   m_adr,
    input  logic [NUM_MASTERS-1:0][DAT_W-1:0]   m_dat_w,
    input  logic [NUM_MASTERS-1:0][SEL_W-1:0]   m_sel,
    output logic [NUM_MASTERS-1:0]              m_ack,
    output logic [DAT_W-1:0]                    m_dat_r,

    // pads
    input  logic [GPIO_WIDTH-1:0]               gpio_in,
    output logic [GPIO_WIDTH-1:0]               gpio_out
);

    // arbiter to decoder
    logic             cyc;
    logic             stb;
    logic             we;
    logic [ADR_W-1:0] adr;
    logic [DAT_W-1:0] dat_w;
    logic [SEL_W-1:0] sel;
    logic             ack;

    // decoder to slaves
    logic [NUM_SLAVES-1:0]            s_cyc;
    logic [NUM_SLAVES-1:0]            s_stb;
    logic [NUM_SLAVES-1:0]            s_we;
    logic [NUM_SLAVES-1:0][ADR_W-1:0] s_adr;
    logic [NUM_SLAVES-1:0][DAT_W-1:0] s_dat_w;
    logic [NUM_SLAVES-1:0][SEL_W-1:0] s_sel;
    logic [NUM_SLAVES-1:0]            s_ack;
    logic [NUM_SLAVES-1:0][DAT_W-1:0] s_dat_r;

    wb_arbiter i_arbiter (
        .CLK(CLK), .nRST(nRST),
        .m_cyc(m_cyc), .m_stb(m_stb), .m_we(m_we),
        .m_adr(m_adr), .m_dat_w(m_dat_w), .m_sel(m_sel), .m_ack(m_ack),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .sel(sel),
        .ack(ack)
    );

    // read data goes straight back to both masters
    wishbone_decoder i_decoder (
        .CLK(CLK), .nRST(nRST),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .sel(sel),
        .ack(ack), .dat_r(m_dat_r),
        .s_cyc(s_cyc), .s_stb(s_stb), .s_we(s_we), .s_adr(s_adr),
        .s_dat_w(s_dat_w), .s_sel(s_sel), .s_ack(s_ack), .s_dat_r(s_dat_r)
    );

    wb_sram i_sram (
        .CLK(CLK), .nRST(nRST),
        .cyc(s_cyc[SLOT_SRAM]), .stb(s_stb[SLOT_SRAM]), .we(s_we[SLOT_SRAM]),
        .adr(s_adr[SLOT_SRAM]), .dat_w(s_dat_w[SLOT_SRAM]), .sel(s_sel[SLOT_SRAM]),
        .ack(s_ack[SLOT_SRAM]), .dat_r(s_dat_r[SLOT_SRAM])
    );

    wb_gpio i_gpio (
        .CLK(CLK), .nRST(nRST),
        .cyc(s_cyc[SLOT_GPIO]), .stb(s_stb[SLOT_GPIO]), .we(s_we[SLOT_GPIO]),
        .adr(s_adr[SLOT_GPIO]), .dat_w(s_dat_w[SLOT_GPIO]), .sel(s_sel[SLOT_GPIO]),
        .ack(s_ack[SLOT_GPIO]), .dat_r(s_dat_r[SLOT_GPIO]),
        .gpio_in(gpio_in), .gpio_out(gpio_out)
    );

    ////////////////////
    // team windows
    ////////////////////
    for (genvar t = 0; t < NUM_TEAMS; t++) begin : g_team
        team_regs i_team (
            .CLK(CLK), .nRST(nRST),
            .cyc(s_cyc[SLOT_TEAM0 + t]), .stb(s_stb[SLOT_TEAM0 + t]),
            .we(s_we[SLOT_TEAM0 + t]), .adr(s_adr[SLOT_TEAM0 + t]),
            .dat_w(s_dat_w[SLOT_TEAM0 + t]), .sel(s_sel[SLOT_TEAM0 + t]),
            .ack(s_ack[SLOT_TEAM0 + t]), .dat_r(s_dat_r[SLOT_TEAM0 + t])
        );
    end

endmodule

// File: verilog/wishbone_decoder.sv
`timescale 1ns/1ns

module wishbone_decoder import wb_pkg::*; (
    input  logic                               CLK,
    input  logic                               nRST,

    // granted master's cycle
    input  logic                               cyc,
    input  logic                               stb,
    input  logic                               we,
    input  logic [ADR_W-1:0]                   adr,
    input  logic [DAT_W-1:0]                   dat_w,
    input  logic [SEL_W-1:0]                   sel,
    output logic                               ack,
    output logic [DAT_W-1:0]                   dat_r,

    // one slot per slave
    output logic [NUM_SLAVES-1:0]              s_cyc,
    output logic [NUM_SLAVES-1:0]              s_stb,
    output logic [NUM_SLAVES-1:0]              s_we,
    output logic [NUM_SLAVES-1:0][ADR_W-1:0]   s_adr,
    output logic [NUM_SLAVES-1:0][DAT_W-1:0]   s_dat_w,
    output logic [NUM_SLAVES-1:0][SEL_W-1:0]   s_sel,
    input  logic [NUM_SLAVES-1:0]              s_ack,
    input  logic [NUM_SLAVES-1:0][DAT_W-1:0]   s_dat_r
);

    logic [ST_W-1:0]   curr_state;
    logic [ST_W-1:0]   next_state;
    logic              ack_reg;
    logic              next_ack;
    logic [DAT_W-1:0]  dat_reg;
    logic [DAT_W-1:0]  next_dat;
    wb_addr_u          a;
    logic              hit;
    logic [SLOT_W-1:0] hit_slot;

    assign a     = adr;
    assign ack   = ack_reg;
    assign dat_r = dat_reg;

    ////////////////////
    // state and ack
    ////////////////////
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            curr_state <= ST_W'(1) << ST_IDLE;
            ack_reg    <= 1'b0;
        end else begin
            curr_state <= next_state;
            ack_reg    <= next_ack;
        end
    end

    // word returned with the ack
    always_ff @(posedge CLK) begin
        dat_reg <= next_dat;
    end

    // fixed pages decoded first and the team window after
    always_comb begin
        hit      = 1'b1;
        hit_slot = '0;
        if (a.fixed.page == PAGE_SRAM) begin
            hit_slot = SLOT_W'(SLOT_SRAM);
        end else if (a.fixed.page == PAGE_GPIO) begin
            hit_slot = SLOT_W'(SLOT_GPIO);
        end else if (a.team.region == REGION_TEAM && a.team.team < NUM_TEAMS) begin
            hit_slot = SLOT_W'(SLOT_TEAM0 + a.team.team);
        end else begin
            // la window and anything else
            hit = 1'b0;
        end
    end

    ////////////////////
    // next state, slave drive
    ////////////////////
    always_comb begin
        next_state = curr_state;
        next_ack   = 1'b0;
        next_dat   = dat_reg;
        s_cyc      = '0;
        s_stb      = '0;
        s_we       = '0;
        s_adr      = '0;
        s_dat_w    = '0;
        s_sel      = '0;

        if (curr_state[ST_IDLE] && cyc && stb) begin
            if (hit) begin
                next_state = ST_W'(1) << (hit_slot + 1);
            end else begin
                // unmapped address answered at once with filler
                next_state = ST_W'(1) << ST_RESP;
                next_ack   = 1'b1;
                next_dat   = UNMAPPED_DATA;
            end
        end

        // sel state i+1 drives slot i
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (curr_state[i + 1]) begin
                s_cyc[i]   = cyc;
                s_stb[i]   = stb;
                s_we[i]    = we;
                s_adr[i]   = adr;
                s_dat_w[i] = dat_w;
                s_sel[i]   = sel;
                if (!cyc) begin
                    // master gave up so drop back
                    next_state = ST_W'(1) << ST_IDLE;
                end else if (s_ack[i]) begin
                    next_state = ST_W'(1) << ST_RESP;
                    next_ack   = 1'b1;
                    next_dat   = s_dat_r[i];
                end
            end
        end

        // one ack cycle with stb ignored
        if (curr_state[ST_RESP]) begin
            next_state = ST_W'(1) << ST_IDLE;
        end
    end

endmodule
